//--- Bender.yml
package:
  name: video_ctrl

sources:
  - files:
      - source/video_regs_pkg.sv
      - source/video_timing_pkg.sv
      - source/port_bus_if.sv
      - source/port_write_queue.sv
      - source/port_decoder.sv
      - source/video_ports.sv
      - source/raster_timing.sv
      - source/video_ctrl_top.sv
  - target: simulation
    files:
      - sim/video_ctrl_checker.sv
      - sim/video_ctrl_monitor.sv
      - sim/video_ctrl_tb.sv

//--- sim/video_ctrl_checker.sv
// credit and interrupt assertions, bound into the port write queue and into the raster counters.
module video_ctrl_checker
(
    input logic clk,
    input logic rst,
    input logic ce,
    input logic io_wr,
    input logic io_credit,
    input logic frame_int
);

    localparam int DEPTH = int'(video_regs_pkg::QUEUE_DEPTH);

    int outstanding = 0;   // writes not yet credited.
    int high_ticks  = 0;
    int fail_count  = 0;

    always @(posedge clk)
    begin
        if (rst)
            outstanding <= 0;
        else
            outstanding <= outstanding + int'(io_wr) - int'(io_credit);
        if (rst || !frame_int)
            high_ticks <= 0;
        else if (ce)
            high_ticks <= high_ticks + 1;   // ce ticks seen with the interrupt up.
    end

    // ####################
    // credits
    // ####################
    credit_limit: assert property (@(posedge clk) disable iff (rst)
        outstanding + int'(io_wr) - int'(io_credit) <= DEPTH)
    else
    begin
        $error("cpu wrote with no credit left");
        fail_count++;
    end

    credit_owed: assert property (@(posedge clk) disable iff (rst) io_credit |-> outstanding > 0)
    else
    begin
        $error("credit returned with no write outstanding");
        fail_count++;
    end

    // ####################
    // interrupt
    // ####################
    int_length: assert property (@(posedge clk) disable iff (rst)
        $fell(frame_int) |-> high_ticks == video_timing_pkg::INT_LEN)
    else
    begin
        $error("frame interrupt pulse has the wrong length");
        fail_count++;
    end

endmodule

bind port_write_queue video_ctrl_checker i_credit_chk
(
    .clk       (clk),
    .rst       (rst),
    .ce        (1'b0),
    .io_wr     (io_wr),
    .io_credit (io_credit),
    .frame_int (1'b0)
);

bind raster_timing video_ctrl_checker i_int_chk
(
    .clk       (clk),
    .rst       (rst),
    .ce        (ce),
    .io_wr     (1'b0),
    .io_credit (1'b0),
    .frame_int (frame_int)
);

//--- sim/video_ctrl_monitor.sv
// reference model of the video control block; compares every DUT output each cycle and counts errors.
module video_ctrl_monitor
(
    input logic        clk,
    input logic        rst,
    input logic        ce,
    input logic        io_wr,
    input logic [15:0] io_addr,
    input logic [7:0]  io_data,
    input logic        io_credit,
    input logic [7:0]  border,
    input logic [7:0]  vpage,
    input logic [7:0]  vconf,
    input logic [8:0]  x_offs,
    input logic [8:0]  y_offs,
    input logic [3:0]  palsel,
    input logic [7:0]  hint_beg,
    input logic [8:0]  vint_beg,
    input logic [7:0]  tsconf,
    input logic [7:0]  tmpage,
    input logic [7:0]  t0gpage,
    input logic [7:0]  t1gpage,
    input logic [7:0]  sgpage,
    input logic [8:0]  hcount,
    input logic [8:0]  vcount,
    input logic        frame_int,
    input logic        end_of_test
);

    localparam int H_LAST = int'(video_timing_pkg::LINE_LEN) - 1;
    localparam int V_LAST = int'(video_timing_pkg::FRAME_LINES) - 1;

    int value_errors    = 0;
    int protocol_errors = 0;
    int n_writes        = 0;
    int n_credits       = 0;
    int q_count;               // entries still waiting in the DUT queue.
    logic checking = 1'b0;
    logic exp_credit;
    logic [15:0] wq_addr [$];  // accepted writes not yet credited.
    logic [7:0]  wq_data [$];

    logic [7:0] m_border, m_vconf, m_tsconf, m_tmpage, m_t0gpage, m_t1gpage, m_sgpage, m_hint;
    logic [3:0] m_palsel;
    logic [8:0] m_vint;
    logic [7:0] p_vpage, m_vpage;
    logic [8:0] p_xoffs, m_xoffs;
    logic [8:0] p_yoffs, m_yoffs;

    int   m_h;
    int   m_v;
    int   int_left;
    logic m_fs;
    logic m_int;
    logic hit;
    logic wrap;

    task compare(input string name, input logic [15:0] expected, input logic [15:0] actual);
        if (expected !== actual)
        begin
            value_errors++;
            $display("FAIL %s at %0t: expected %0h, actual %0h", name, $time, expected, actual);
        end
    endtask

    task apply_write(input logic [15:0] addr, input logic [7:0] data);
        if (addr[7:0] == video_regs_pkg::PORT_EXT_LO)
        begin
            case (addr[15:8])
                8'h00: m_vconf = data;
                8'h01: p_vpage = data;
                8'h02: p_xoffs[7:0] = data;
                8'h03: p_xoffs[8] = data[0];
                8'h04: p_yoffs[7:0] = data;
                8'h05: p_yoffs[8] = data[0];
                8'h06: m_tsconf = data;
                8'h07: m_palsel = data[3:0];
                8'h0F: m_border = data;
                8'h16: m_tmpage = data;
                8'h17: m_t0gpage = data;
                8'h18: m_t1gpage = data;
                8'h19: m_sgpage = data;
                8'h22: m_hint = data;
                8'h23: m_vint[7:0] = data;
                8'h24: m_vint[8] = data[0];
                default: ;   // unmapped high byte.
            endcase
        end
        else if (addr == video_regs_pkg::PORT_ZVPAGE)
            p_vpage = data[3] ? 8'h07 : 8'h05;
        else if (addr[7:0] == video_regs_pkg::PORT_ZBORDER_LO)
            m_border = 8'hF0 | {5'b00000, data[2:0]};
    endtask

    task reset_model();
        m_border  = 8'h00;
        m_vconf   = video_regs_pkg::RST_VCONF;
        m_palsel  = video_regs_pkg::RST_PALSEL;
        m_hint    = video_regs_pkg::RST_HINT_BEG;
        m_vint    = 9'd0;
        m_tsconf  = 8'h00;
        m_tmpage  = 8'h00;
        m_t0gpage = 8'h00;
        m_t1gpage = 8'h00;
        m_sgpage  = 8'h00;
        p_vpage   = video_regs_pkg::RST_VPAGE;
        m_vpage   = video_regs_pkg::RST_VPAGE;
        p_xoffs   = 9'd0;
        m_xoffs   = 9'd0;
        p_yoffs   = 9'd0;
        m_yoffs   = 9'd0;
        m_h       = 0;
        m_v       = 0;
        int_left  = 0;
        m_fs      = 1'b0;
        m_int     = 1'b0;
        q_count   = 0;
        exp_credit = 1'b0;
        wq_addr.delete();
        wq_data.delete();
    endtask

    // ####################
    // model step on each rising edge
    // ####################
    always @(posedge clk)
    begin
        checking = !rst;
        if (rst)
            reset_model();
        else
        begin
            // raster decisions use the values from before this edge.
            hit  = ce && (m_v == int'(m_vint)) && (m_h == int'(m_hint) * video_timing_pkg::HINT_SCALE);
            wrap = ce && (m_h == H_LAST) && (m_v == V_LAST);
            if (hit)
            begin
                m_int    = 1'b1;
                int_left = video_timing_pkg::INT_LEN;
            end
            else if (ce && m_int)
            begin
                int_left--;
                if (int_left == 0)
                    m_int = 1'b0;
            end
            if (ce)
            begin
                if (m_h == H_LAST)
                begin
                    m_h = 0;
                    m_v = (m_v == V_LAST) ? 0 : m_v + 1;
                end
                else
                    m_h++;
            end
            if (m_fs)
            begin
                m_vpage = p_vpage;
                m_xoffs = p_xoffs;
                m_yoffs = p_yoffs;
            end
            m_fs = wrap;
            // a returned credit means the write lands on this edge.
            if (io_credit)
            begin
                n_credits++;
                if (wq_addr.size() == 0)
                begin
                    protocol_errors++;
                    $display("credit returned at %0t with no write outstanding", $time);
                end
                else
                    apply_write(wq_addr.pop_front(), wq_data.pop_front());
            end
            exp_credit = ce && (q_count > 0);
            q_count = q_count + int'(io_wr) - int'(exp_credit);
            if (io_wr)
            begin
                wq_addr.push_back(io_addr);
                wq_data.push_back(io_data);
                n_writes++;
            end
        end
    end

    // outputs are stable on the falling edge.
    always @(negedge clk)
    begin
        if (checking)
        begin
            compare("credit.io_credit", 16'(exp_credit), 16'(io_credit));
            compare("regs.border", 16'(m_border), 16'(border));
            compare("regs.vconf", 16'(m_vconf), 16'(vconf));
            compare("regs.palsel", 16'(m_palsel), 16'(palsel));
            compare("regs.hint_beg", 16'(m_hint), 16'(hint_beg));
            compare("regs.vint_beg", 16'(m_vint), 16'(vint_beg));
            compare("regs.tsconf", 16'(m_tsconf), 16'(tsconf));
            compare("regs.tmpage", 16'(m_tmpage), 16'(tmpage));
            compare("regs.t0gpage", 16'(m_t0gpage), 16'(t0gpage));
            compare("regs.t1gpage", 16'(m_t1gpage), 16'(t1gpage));
            compare("regs.sgpage", 16'(m_sgpage), 16'(sgpage));
            compare("latch.vpage", 16'(m_vpage), 16'(vpage));
            compare("latch.x_offs", 16'(m_xoffs), 16'(x_offs));
            compare("latch.y_offs", 16'(m_yoffs), 16'(y_offs));
            compare("raster.hcount", 16'(m_h), 16'(hcount));
            compare("raster.vcount", 16'(m_v), 16'(vcount));
            compare("raster.frame_int", 16'(m_int), 16'(frame_int));
        end
    end

    always @(posedge end_of_test)
    begin
        compare("credit.returned", 16'(n_writes), 16'(n_credits));
    end

endmodule

//--- sim/video_ctrl_tb.sv
// testbench top: random CPU port writes under credit flow control, random ce, two raster frames.
module video_ctrl_tb;

    localparam int PERIOD      = 8;
    localparam int NUM_WRITES  = 400;
    localparam int FRAME_TICKS = int'(video_timing_pkg::LINE_LEN) *
                                 int'(video_timing_pkg::FRAME_LINES);
    // every write and two frames budgeted at a quarter ce rate.
    localparam int TIMEOUT     = (NUM_WRITES * 64 + 2 * FRAME_TICKS * 4 + 2000) * PERIOD;
    localparam logic [127:0] EXT_CODES = {8'h24, 8'h23, 8'h22, 8'h19, 8'h18, 8'h17, 8'h16, 8'h0F,
                                          8'h07, 8'h06, 8'h05, 8'h04, 8'h03, 8'h02, 8'h01, 8'h00};

    logic        clk;
    logic        rst;
    logic        ce;
    logic        io_wr;
    logic [15:0] io_addr;
    logic [7:0]  io_data;
    logic        io_credit;
    logic [7:0]  border;
    logic [7:0]  vpage;
    logic [7:0]  vconf;
    logic [8:0]  x_offs;
    logic [8:0]  y_offs;
    logic [3:0]  palsel;
    logic [7:0]  hint_beg;
    logic [8:0]  vint_beg;
    logic [7:0]  tsconf;
    logic [7:0]  tmpage;
    logic [7:0]  t0gpage;
    logic [7:0]  t1gpage;
    logic [7:0]  sgpage;
    logic [8:0]  hcount;
    logic [8:0]  vcount;
    logic        frame_int;
    logic        end_of_test;

    logic [31:0] lfsr    = 32'h5cbf_2f82;
    int          credits = int'(video_regs_pkg::QUEUE_DEPTH);
    int          issued  = 0;
    int          ticks   = 0;
    int          asserts;
    int          errors;

    video_ctrl_top i_dut (.*);

    video_ctrl_monitor i_mon (.*);

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // galois, taps 32 22 2 1.
    endfunction

    function logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // one clock of the CPU side: pick up a returned credit, then drive ce and at most one write.
    task automatic cpu_cycle(input logic ce_val, input logic want_wr,
                             input logic [15:0] addr, input logic [7:0] data);
        @(negedge clk);
        if (io_credit)
            credits++;
        ce = ce_val;
        if (ce_val)
            ticks++;
        if (want_wr && credits > 0)
        begin
            io_wr   = 1'b1;
            io_addr = addr;
            io_data = data;
            credits--;
            issued++;
        end
        else
            io_wr = 1'b0;
    endtask

    task automatic random_cycle(input logic allow_wr);
        logic        ce_val;
        logic        want;
        logic [2:0]  sel;
        logic [3:0]  idx;
        logic [15:0] addr;
        logic [7:0]  data;
        ce_val = 1'(take_bits(1));
        want   = allow_wr && 1'(take_bits(1));
        addr   = '0;
        data   = '0;
        if (want)
        begin
            sel = 3'(take_bits(3));
            idx = 4'(take_bits(4));
            case (sel)
                3'd4: addr = {8'(take_bits(8)), video_regs_pkg::PORT_EXT_LO};   // mostly unmapped.
                3'd5: addr = {8'(take_bits(8)), video_regs_pkg::PORT_ZBORDER_LO};
                3'd6: addr = video_regs_pkg::PORT_ZVPAGE;
                3'd7: addr = video_regs_pkg::PORT_ZVPAGE ^ (16'd1 << idx);   // near miss.
                default: addr = {EXT_CODES[idx * 8 +: 8], video_regs_pkg::PORT_EXT_LO};
            endcase
            data = 8'(take_bits(8));
        end
        cpu_cycle(ce_val, want, addr, data);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(TIMEOUT);
        $display("watchdog: run did not finish within %0d time units", TIMEOUT);
        $display("Testbench failed");
        $finish;
    end

    initial
    begin
        rst         = 1'b1;
        ce          = 1'b0;
        io_wr       = 1'b0;
        io_addr     = '0;
        io_data     = '0;
        end_of_test = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        while (issued < NUM_WRITES)
            random_cycle(1'b1);
        while (credits < int'(video_regs_pkg::QUEUE_DEPTH))
            random_cycle(1'b0);

        // ####################
        // fill the queue with ce held low
        // ####################
        cpu_cycle(1'b0, 1'b1, 16'h24AF, 8'h00);
        cpu_cycle(1'b0, 1'b1, 16'h23AF, 8'h10);   // interrupt on line 16.
        cpu_cycle(1'b0, 1'b1, 16'h22AF, 8'h20);
        cpu_cycle(1'b0, 1'b1, 16'h03AF, 8'h01);
        repeat (20) cpu_cycle(1'b0, 1'b0, '0, '0);

        ticks = 0;
        while (ticks < 2 * FRAME_TICKS + int'(video_timing_pkg::LINE_LEN))
            random_cycle(1'b0);

        cpu_cycle(1'b0, 1'b0, '0, '0);
        end_of_test = 1'b1;
        repeat (2) @(negedge clk);
        asserts = i_dut.i_queue.i_credit_chk.fail_count + i_dut.i_raster.i_int_chk.fail_count;
        errors  = i_mon.value_errors + i_mon.protocol_errors + asserts;
        $display("errors: %0d value, %0d protocol, %0d assertion",
                 i_mon.value_errors, i_mon.protocol_errors, asserts);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- source/port_bus_if.sv
// carries the head of the port write queue to the decoder; an entry leaves on valid and take.
interface port_bus_if;

    logic        valid;
    logic        take;
    logic [15:0] addr;
    logic [7:0]  data;

    modport source
    (
        output valid,
        output addr,
        output data,
        input  take
    );

    modport sink
    (
        input  valid,
        input  addr,
        input  data,
        output take
    );

endinterface

//--- source/port_decoder.sv
// takes queued port writes on ce cycles and registers a one-hot register strobe with its data.
module port_decoder
(
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               ce,
    port_bus_if.sink                           bus,
    output logic [video_regs_pkg::NUM_REGS-1:0] wr_strobe,
    output logic [7:0]                         wr_data
);

    logic [video_regs_pkg::NUM_REGS-1:0] dec_strobe;

    // back-pressure is just ce low.
    assign bus.take = ce;

    always_comb
    begin
        dec_strobe = '0;
        if (bus.addr[7:0] == video_regs_pkg::PORT_EXT_LO)
        begin
            case (bus.addr[15:8])
                video_regs_pkg::EXT_VCONF:     dec_strobe[video_regs_pkg::REG_VCONF]     = 1'b1;
                video_regs_pkg::EXT_VPAGE:     dec_strobe[video_regs_pkg::REG_VPAGE]     = 1'b1;
                video_regs_pkg::EXT_XOFFSL:    dec_strobe[video_regs_pkg::REG_XOFFSL]    = 1'b1;
                video_regs_pkg::EXT_XOFFSH:    dec_strobe[video_regs_pkg::REG_XOFFSH]    = 1'b1;
                video_regs_pkg::EXT_YOFFSL:    dec_strobe[video_regs_pkg::REG_YOFFSL]    = 1'b1;
                video_regs_pkg::EXT_YOFFSH:    dec_strobe[video_regs_pkg::REG_YOFFSH]    = 1'b1;
                video_regs_pkg::EXT_TSCONF:    dec_strobe[video_regs_pkg::REG_TSCONF]    = 1'b1;
                video_regs_pkg::EXT_PALSEL:    dec_strobe[video_regs_pkg::REG_PALSEL]    = 1'b1;
                video_regs_pkg::EXT_BORDER:    dec_strobe[video_regs_pkg::REG_BORDER]    = 1'b1;
                video_regs_pkg::EXT_TMPAGE:    dec_strobe[video_regs_pkg::REG_TMPAGE]    = 1'b1;
                video_regs_pkg::EXT_T0GPAGE:   dec_strobe[video_regs_pkg::REG_T0GPAGE]   = 1'b1;
                video_regs_pkg::EXT_T1GPAGE:   dec_strobe[video_regs_pkg::REG_T1GPAGE]   = 1'b1;
                video_regs_pkg::EXT_SGPAGE:    dec_strobe[video_regs_pkg::REG_SGPAGE]    = 1'b1;
                video_regs_pkg::EXT_HINT_BEG:  dec_strobe[video_regs_pkg::REG_HINT_BEG]  = 1'b1;
                video_regs_pkg::EXT_VINT_BEGL: dec_strobe[video_regs_pkg::REG_VINT_BEGL] = 1'b1;
                video_regs_pkg::EXT_VINT_BEGH: dec_strobe[video_regs_pkg::REG_VINT_BEGH] = 1'b1;
                default:                       dec_strobe = '0;
            endcase
        end
        else if (bus.addr == video_regs_pkg::PORT_ZVPAGE)
            dec_strobe[video_regs_pkg::REG_ZVPAGE] = 1'b1;
        else if (bus.addr[7:0] == video_regs_pkg::PORT_ZBORDER_LO)
            dec_strobe[video_regs_pkg::REG_ZBORDER] = 1'b1;
    end

    // unmapped entries are still taken, they just strobe nothing.
    always_ff @(posedge clk)
    begin
        if (rst)
            wr_strobe <= '0;
        else if (bus.valid && bus.take)
            wr_strobe <= dec_strobe;
        else
            wr_strobe <= '0;
    end

    always_ff @(posedge clk)
    begin
        if (bus.valid && bus.take)
            wr_data <= bus.data;
    end

endmodule

//--- source/port_write_queue.sv
// four-entry FIFO of CPU port writes; hands back one credit per entry taken by the decoder.
module port_write_queue
(
    input  logic        clk,
    input  logic        rst,
    input  logic        io_wr,
    input  logic [15:0] io_addr,
    input  logic [7:0]  io_data,
    output logic        io_credit,
    port_bus_if.source  bus
);

    localparam int DEPTH = int'(video_regs_pkg::QUEUE_DEPTH);
    localparam int PTR_W = $clog2(DEPTH);

    logic [15:0]      addr_mem [DEPTH];
    logic [7:0]       data_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [2:0]       count;
    logic             pop;

    assign pop       = bus.valid && bus.take;
    assign bus.valid = (count != 3'd0);
    assign bus.addr  = addr_mem[rd_ptr];
    assign bus.data  = data_mem[rd_ptr];

    // the credit protocol guarantees room on every io_wr.
    always_ff @(posedge clk)
    begin
        if (io_wr)
        begin
            addr_mem[wr_ptr] <= io_addr;
            data_mem[wr_ptr] <= io_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= 3'd0;
            io_credit <= 1'b0;
        end
        else
        begin
            if (io_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count     <= count + {2'b0, io_wr} - {2'b0, pop};
            io_credit <= pop;   // credit back the cycle after the take.
        end
    end

endmodule

//--- source/raster_timing.sv
// line and frame counters on the ce enable, frame start pulse and the programmable frame interrupt.
module raster_timing
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ce,
    input  logic [7:0] hint_beg,
    input  logic [8:0] vint_beg,
    output logic [8:0] hcount,
    output logic [8:0] vcount,
    output logic       frame_start,
    output logic       frame_int
);

    localparam int CNT_W = $clog2(video_timing_pkg::INT_LEN);

    logic [9:0]       hint_pos;
    logic             line_end;
    logic             frame_end;
    logic             int_hit;
    logic [CNT_W-1:0] int_cnt;

    assign hint_pos  = 10'(hint_beg) * 10'(video_timing_pkg::HINT_SCALE);
    assign line_end  = (hcount == video_timing_pkg::LINE_LEN - 9'd1);
    assign frame_end = line_end && (vcount == video_timing_pkg::FRAME_LINES - 9'd1);
    assign int_hit   = ce && (vcount == vint_beg) && ({1'b0, hcount} == hint_pos);

    // ####################
    // counters
    // ####################
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            hcount      <= 9'd0;
            vcount      <= 9'd0;
            frame_start <= 1'b0;
        end
        else
        begin
            frame_start <= ce && frame_end;   // high while both counters read zero.
            if (ce)
            begin
                hcount <= line_end ? 9'd0 : hcount + 9'd1;
                if (frame_end)
                    vcount <= 9'd0;
                else if (line_end)
                    vcount <= vcount + 9'd1;
            end
        end
    end

    // ####################
    // interrupt
    // ####################
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            frame_int <= 1'b0;
            int_cnt   <= '0;
        end
        else if (int_hit)
        begin
            frame_int <= 1'b1;
            int_cnt   <= CNT_W'(video_timing_pkg::INT_LEN - 1);
        end
        else if (ce && frame_int)
        begin
            if (int_cnt == '0)
                frame_int <= 1'b0;   // INT_LEN ticks done.
            else
                int_cnt <= int_cnt - 1'b1;
        end
    end

endmodule

//--- source/video_ctrl_top.sv
// video control block top: CPU port writes in, latched video parameters and raster timing out.
module video_ctrl_top
(
    input  logic        clk,
    input  logic        rst,
    input  logic        ce,
    input  logic        io_wr,
    input  logic [15:0] io_addr,
    input  logic [7:0]  io_data,
    output logic        io_credit,
    output logic [7:0]  border,
    output logic [7:0]  vpage,
    output logic [7:0]  vconf,
    output logic [8:0]  x_offs,
    output logic [8:0]  y_offs,
    output logic [3:0]  palsel,
    output logic [7:0]  hint_beg,
    output logic [8:0]  vint_beg,
    output logic [7:0]  tsconf,
    output logic [7:0]  tmpage,
    output logic [7:0]  t0gpage,
    output logic [7:0]  t1gpage,
    output logic [7:0]  sgpage,
    output logic [8:0]  hcount,
    output logic [8:0]  vcount,
    output logic        frame_int
);

    logic [video_regs_pkg::NUM_REGS-1:0] wr_strobe;
    logic [7:0]                          wr_data;
    logic                                frame_start;

    port_bus_if bus ();

    port_write_queue i_queue
    (
        .clk       (clk),
        .rst       (rst),
        .io_wr     (io_wr),
        .io_addr   (io_addr),
        .io_data   (io_data),
        .io_credit (io_credit),
        .bus       (bus.source)
    );

    port_decoder i_decoder
    (
        .clk       (clk),
        .rst       (rst),
        .ce        (ce),
        .bus       (bus.sink),
        .wr_strobe (wr_strobe),
        .wr_data   (wr_data)
    );

    video_ports i_ports
    (
        .clk         (clk),
        .rst         (rst),
        .wr_strobe   (wr_strobe),
        .wr_data     (wr_data),
        .frame_start (frame_start),
        .border      (border),
        .vpage       (vpage),
        .vconf       (vconf),
        .x_offs      (x_offs),
        .y_offs      (y_offs),
        .palsel      (palsel),
        .hint_beg    (hint_beg),
        .vint_beg    (vint_beg),
        .tsconf      (tsconf),
        .tmpage      (tmpage),
        .t0gpage     (t0gpage),
        .t1gpage     (t1gpage),
        .sgpage      (sgpage)
    );

    raster_timing i_raster
    (
        .clk         (clk),
        .rst         (rst),
        .ce          (ce),
        .hint_beg    (hint_beg),
        .vint_beg    (vint_beg),
        .hcount      (hcount),
        .vcount      (vcount),
        .frame_start (frame_start),
        .frame_int   (frame_int)
    );

endmodule

//--- source/video_ports.sv
// video parameter registers written by decoded port strobes; scroll and page apply at frame start.
module video_ports
(
    input  logic                               clk,
    input  logic                               rst,
    input  logic [video_regs_pkg::NUM_REGS-1:0] wr_strobe,
    input  logic [7:0]                         wr_data,
    input  logic                               frame_start,
    output logic [7:0]                         border,
    output logic [7:0]                         vpage,
    output logic [7:0]                         vconf,
    output logic [8:0]                         x_offs,
    output logic [8:0]                         y_offs,
    output logic [3:0]                         palsel,
    output logic [7:0]                         hint_beg,
    output logic [8:0]                         vint_beg,
    output logic [7:0]                         tsconf,
    output logic [7:0]                         tmpage,
    output logic [7:0]                         t0gpage,
    output logic [7:0]                         t1gpage,
    output logic [7:0]                         sgpage
);

    // written values waiting for the next frame.
    logic [7:0] vpage_p;
    logic [8:0] x_offs_p;
    logic [8:0] y_offs_p;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            vpage_p  <= video_regs_pkg::RST_VPAGE;
            x_offs_p <= 9'd0;
            y_offs_p <= 9'd0;
            border   <= 8'h00;
            vconf    <= video_regs_pkg::RST_VCONF;
            palsel   <= video_regs_pkg::RST_PALSEL;
            hint_beg <= video_regs_pkg::RST_HINT_BEG;
            vint_beg <= 9'd0;
            tsconf   <= 8'h00;
            tmpage   <= 8'h00;
            t0gpage  <= 8'h00;
            t1gpage  <= 8'h00;
            sgpage   <= 8'h00;
        end
        else
        begin
            if (wr_strobe[video_regs_pkg::REG_ZBORDER])   border <= {5'b11110, wr_data[2:0]};
            if (wr_strobe[video_regs_pkg::REG_BORDER])    border <= wr_data;
            if (wr_strobe[video_regs_pkg::REG_ZVPAGE])    vpage_p <= {6'b000001, wr_data[3], 1'b1};
            if (wr_strobe[video_regs_pkg::REG_VPAGE])     vpage_p <= wr_data;
            if (wr_strobe[video_regs_pkg::REG_VCONF])     vconf <= wr_data;
            if (wr_strobe[video_regs_pkg::REG_XOFFSL])    x_offs_p[7:0] <= wr_data;
            if (wr_strobe[video_regs_pkg::REG_XOFFSH])    x_offs_p[8] <= wr_data[0];
            if (wr_strobe[video_regs_pkg::REG_YOFFSL])    y_offs_p[7:0] <= wr_data;
            if (wr_strobe[video_regs_pkg::REG_YOFFSH])    y_offs_p[8] <= wr_data[0];
            if (wr_strobe[video_regs_pkg::REG_TSCONF])    tsconf <= wr_data;
            if (wr_strobe[video_regs_pkg::REG_PALSEL])    palsel <= wr_data[3:0];
            if (wr_strobe[video_regs_pkg::REG_TMPAGE])    tmpage <= wr_data;
            if (wr_strobe[video_regs_pkg::REG_T0GPAGE])   t0gpage <= wr_data;
            if (wr_strobe[video_regs_pkg::REG_T1GPAGE])   t1gpage <= wr_data;
            if (wr_strobe[video_regs_pkg::REG_SGPAGE])    sgpage <= wr_data;
            if (wr_strobe[video_regs_pkg::REG_HINT_BEG])  hint_beg <= wr_data;
            if (wr_strobe[video_regs_pkg::REG_VINT_BEGL]) vint_beg[7:0] <= wr_data;
            if (wr_strobe[video_regs_pkg::REG_VINT_BEGH]) vint_beg[8] <= wr_data[0];
        end
    end

    // ####################
    // frame latch
    // ####################
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            vpage  <= video_regs_pkg::RST_VPAGE;
            x_offs <= 9'd0;
            y_offs <= 9'd0;
        end
        else if (frame_start)
        begin
            vpage  <= vpage_p;
            x_offs <= x_offs_p;
            y_offs <= y_offs_p;
        end
    end

endmodule

//--- source/video_regs_pkg.sv
// port map, register indices and reset values shared by the CPU port write path.
package video_regs_pkg;

    // ####################
    // queue
    // ####################
    localparam logic [2:0] QUEUE_DEPTH = 3'd4;   // also the CPU's credits after reset.

    // ####################
    // write strobe bit indices
    // ####################
    localparam int REG_VCONF     = 0;
    localparam int REG_VPAGE     = 1;
    localparam int REG_XOFFSL    = 2;
    localparam int REG_XOFFSH    = 3;
    localparam int REG_YOFFSL    = 4;
    localparam int REG_YOFFSH    = 5;
    localparam int REG_TSCONF    = 6;
    localparam int REG_PALSEL    = 7;
    localparam int REG_BORDER    = 8;
    localparam int REG_TMPAGE    = 9;
    localparam int REG_T0GPAGE   = 10;
    localparam int REG_T1GPAGE   = 11;
    localparam int REG_SGPAGE    = 12;
    localparam int REG_HINT_BEG  = 13;
    localparam int REG_VINT_BEGL = 14;
    localparam int REG_VINT_BEGH = 15;
    localparam int REG_ZBORDER   = 16;   // legacy.
    localparam int REG_ZVPAGE    = 17;   // legacy.
    localparam int NUM_REGS      = 18;

    // ####################
    // port addresses
    // ####################
    localparam logic [7:0]  PORT_EXT_LO     = 8'hAF;    // extended scheme, high byte selects.
    localparam logic [7:0]  PORT_ZBORDER_LO = 8'hFE;
    localparam logic [15:0] PORT_ZVPAGE     = 16'h7FFD;

    localparam logic [7:0] EXT_VCONF     = 8'h00;
    localparam logic [7:0] EXT_VPAGE     = 8'h01;
    localparam logic [7:0] EXT_XOFFSL    = 8'h02;
    localparam logic [7:0] EXT_XOFFSH    = 8'h03;
    localparam logic [7:0] EXT_YOFFSL    = 8'h04;
    localparam logic [7:0] EXT_YOFFSH    = 8'h05;
    localparam logic [7:0] EXT_TSCONF    = 8'h06;
    localparam logic [7:0] EXT_PALSEL    = 8'h07;
    localparam logic [7:0] EXT_BORDER    = 8'h0F;
    localparam logic [7:0] EXT_TMPAGE    = 8'h16;
    localparam logic [7:0] EXT_T0GPAGE   = 8'h17;
    localparam logic [7:0] EXT_T1GPAGE   = 8'h18;
    localparam logic [7:0] EXT_SGPAGE    = 8'h19;
    localparam logic [7:0] EXT_HINT_BEG  = 8'h22;
    localparam logic [7:0] EXT_VINT_BEGL = 8'h23;
    localparam logic [7:0] EXT_VINT_BEGH = 8'h24;

    // ####################
    // reset values
    // ####################
    localparam logic [7:0] RST_VPAGE    = 8'h05;
    localparam logic [7:0] RST_VCONF    = 8'h00;
    localparam logic [3:0] RST_PALSEL   = 4'hF;
    localparam logic [7:0] RST_HINT_BEG = 8'd2;   // pentagon timing.

endpackage

//--- source/video_timing_pkg.sv
// raster geometry and interrupt constants for the video timing counters.
package video_timing_pkg;

    localparam logic [8:0] LINE_LEN    = 9'd448;   // ce ticks per line.
    localparam logic [8:0] FRAME_LINES = 9'd320;   // lines per frame.

    // interrupt pulse length in ce ticks.
    localparam int INT_LEN = 32;

    // hint_beg is given in units of this many ticks.
    localparam int HINT_SCALE = 2;

endpackage

//--- tb.f
source/video_regs_pkg.sv
source/video_timing_pkg.sv
source/port_bus_if.sv
source/port_write_queue.sv
source/port_decoder.sv
source/video_ports.sv
source/raster_timing.sv
source/video_ctrl_top.sv
sim/video_ctrl_checker.sv
sim/video_ctrl_monitor.sv
sim/video_ctrl_tb.sv
